// File: Makefile
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal -j 0 \
		--top-module fir_tb -f filelist.f -o Vfir_tb

run: build
	./obj_dir/Vfir_tb > $(LOG) 2>&1; cat $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps \
		--top-module fir_top -f filelist.f

clean:
	rm -rf obj_dir $(LOG)

// File: axil_cfg/axil_cfg.sv
// axi-lite register block of the fir filter: coefficients, length, status and read-back
`timescale 1ns/10ps
`include "fir_cfg.svh"

module axil_cfg (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    awvalid,
    input  logic [`FIR_ADDR_W-1:0]  awaddr,
    input  logic                    wvalid,
    input  logic [`FIR_DATA_W-1:0]  wdata,
    output logic                    awready,
    output logic                    wready,
    input  logic                    arvalid,
    input  logic [`FIR_ADDR_W-1:0]  araddr,
    output logic                    arready,
    output logic                    rvalid,
    output logic [`FIR_DATA_W-1:0]  rdata,
    input  logic                    rready,
    input  logic                    first_take,
    input  logic                    run_end,
    input  fir_pkg::tap_rd_t        tap_rd,
    output logic [`FIR_DATA_W-1:0]  tap_coef,
    output fir_pkg::run_ctrl_t      run
);

    localparam int TAP_NUM = `FIR_TAP_NUM;
    localparam int IDX_W   = `FIR_TAP_IDX_W;

    fir_pkg::ap_ctrl_t      ap;
    logic                   start_pulse;
    logic [`FIR_DATA_W-1:0] len;
    logic [`FIR_DATA_W-1:0] coef [TAP_NUM];

    logic                   wr_fire;
    logic                   rd_fire;
    logic [`FIR_ADDR_W-1:0] aw_off;
    logic [`FIR_ADDR_W-1:0] ar_off;
    logic                   aw_tap_hit;
    logic                   ar_tap_hit;
    logic [IDX_W-1:0]       aw_idx;
    logic [IDX_W-1:0]       ar_idx;
    logic [`FIR_DATA_W-1:0] rd_word;

    // ********************
    // write channel
    // ********************

    // address and data taken together, no buffering
    assign wr_fire = awvalid & wvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    // coefficient window, word aligned, eleven words
    assign aw_off     = awaddr - `FIR_REG_TAP0;
    assign aw_idx     = aw_off[IDX_W+1:2];
    assign aw_tap_hit = (awaddr >= `FIR_REG_TAP0) && (aw_off[1:0] == 2'b00)
                        && (aw_off[`FIR_ADDR_W-1:2] < TAP_NUM);

    // status flags and length
    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            ap          <= '{idle: 1'b1, done: 1'b0, start: 1'b0};
            start_pulse <= 1'b0;
            len         <= '0;
        end
        else
        begin
            start_pulse <= 1'b0;
            // start only taken from idle
            if (wr_fire && awaddr == `FIR_REG_CTRL && ap.idle && wdata[0])
            begin
                ap.start    <= 1'b1;
                start_pulse <= 1'b1;
            end
            else if (first_take)
                ap.start <= 1'b0;
            // leave idle once the datapath has been cleared
            if (start_pulse)
                ap.idle <= 1'b0;
            else if (run_end)
                ap.idle <= 1'b1;
            // done is read-to-clear, a new end wins
            if (run_end)
                ap.done <= 1'b1;
            else if (rd_fire && araddr == `FIR_REG_CTRL)
                ap.done <= 1'b0;
            if (wr_fire && ap.idle && awaddr == `FIR_REG_LEN)
                len <= wdata;
        end
    end

    // coefficient file, locked while a run is active
    always_ff @(posedge axis_clk)
    begin
        if (wr_fire && ap.idle && aw_tap_hit)
            coef[aw_idx] <= wdata;
    end

    // operand port for the mac
    assign tap_coef = (tap_rd.valid && tap_rd.idx < TAP_NUM) ? coef[tap_rd.idx] : '0;

    assign run.start_pulse = start_pulse;
    assign run.running     = ~ap.idle;
    assign run.len         = len;

    // ********************
    // read channel
    // ********************

    // one outstanding read
    assign arready = ~rvalid;
    assign rd_fire = arvalid & arready;

    assign ar_off     = araddr - `FIR_REG_TAP0;
    assign ar_idx     = ar_off[IDX_W+1:2];
    assign ar_tap_hit = (araddr >= `FIR_REG_TAP0) && (ar_off[1:0] == 2'b00)
                        && (ar_off[`FIR_ADDR_W-1:2] < TAP_NUM);

    always_comb
    begin
        if (araddr == `FIR_REG_CTRL)
            rd_word = {{(`FIR_DATA_W-3){1'b0}}, ap};
        else if (araddr == `FIR_REG_LEN)
            rd_word = len;
        else if (ar_tap_hit)
            rd_word = coef[ar_idx];
        else
            rd_word = `FIR_RDATA_UNMAPPED;
    end

    // response held until rready
    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
            rvalid <= 1'b0;
        else if (rd_fire)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    always_ff @(posedge axis_clk)
    begin
        if (rd_fire)
            rdata <= rd_word;
    end

    // a rising start must come out of the idle state
    a_start_from_idle: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        $rose(ap.start) |-> $past(ap.idle));

endmodule

// File: common/fir_cfg.svh
// widths, tap count and register map of the fir block, included by rtl and testbench
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

// ********************
// datapath sizing
// ********************

// sample, coefficient and result width
`define FIR_DATA_W          32
// host register address width
`define FIR_ADDR_W          12
// filter length
`define FIR_TAP_NUM         11
// enough bits to count 0..tap_num-1
`define FIR_TAP_IDX_W       4

// ********************
// register map
// ********************

`define FIR_REG_CTRL        12'h000
`define FIR_REG_LEN         12'h010
// coefficients follow here, one word every 4 bytes
`define FIR_REG_TAP0        12'h020
`define FIR_RDATA_UNMAPPED  {`FIR_DATA_W{1'b1}}

`endif

// File: common/fir_pkg.sv
// shared packed structs passed between the fir register block and its datapath
`include "fir_cfg.svh"

package fir_pkg;

    // ********************
    // host visible status
    // ********************

    // bit 0 start, bit 1 done, bit 2 idle
    typedef struct packed {
        logic idle;
        logic done;
        logic start;
    } ap_ctrl_t;

    // ********************
    // datapath links
    // ********************

    // one stream word with its end marker
    typedef struct packed {
        logic                   last;
        logic [`FIR_DATA_W-1:0] data;
    } axis_beat_t;

    // run control from the register block
    typedef struct packed {
        logic                   start_pulse;
        logic                   running;
        logic [`FIR_DATA_W-1:0] len;
    } run_ctrl_t;

    // operand request, both answers come back combinationally
    typedef struct packed {
        logic                     valid;
        logic [`FIR_TAP_IDX_W-1:0] idx;
    } tap_rd_t;

endpackage

// File: filelist.f
+incdir+common
+incdir+verification
common/fir_pkg.sv
axil_cfg/axil_cfg.sv
rtl/sample_window.sv
fir_mac/fir_mac.sv
rtl/fir_top.sv
verification/fir_tb.sv

// File: fir_mac/fir_mac.sv
// fir multiply-accumulate sequencer, one tap per cycle into a stream output register
`timescale 1ns/10ps
`include "fir_cfg.svh"

module fir_mac (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  fir_pkg::run_ctrl_t      run,
    input  logic                    sample_rdy,
    output logic                    sample_ack,
    output fir_pkg::tap_rd_t        tap_rd,
    input  logic [`FIR_DATA_W-1:0]  tap_coef,
    input  logic [`FIR_DATA_W-1:0]  hist_word,
    output logic                    sm_tvalid,
    input  logic                    sm_tready,
    output fir_pkg::axis_beat_t     sm_out,
    output logic                    run_end
);

    localparam int               IDX_W  = `FIR_TAP_IDX_W;
    localparam logic [IDX_W-1:0] LAST_K = IDX_W'(`FIR_TAP_NUM - 1);

    logic                   busy;
    logic [IDX_W-1:0]       k;
    logic [`FIR_DATA_W-1:0] acc;
    logic [`FIR_DATA_W-1:0] prod;
    logic [`FIR_DATA_W-1:0] sum;
    logic                   begin_sum;
    logic                   load_ok;
    logic                   load;
    logic [`FIR_DATA_W-1:0] load_cnt;
    logic                   out_valid;
    fir_pkg::axis_beat_t    out_q;

    // ********************
    // tap sequencing
    // ********************

    // low 32 bits only, two's complement wraps
    assign prod = tap_coef * hist_word;
    assign sum  = acc + prod;

    assign begin_sum = ~busy & sample_rdy & run.running;
    // output register free now or emptied this cycle
    assign load_ok   = ~out_valid | sm_tready;
    assign load      = busy & (k == LAST_K) & load_ok;
    // window released only with the final tap
    assign sample_ack = load;

    assign tap_rd.valid = busy;
    assign tap_rd.idx   = k;

    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            busy <= 1'b0;
            k    <= '0;
        end
        else if (run.start_pulse)
        begin
            busy <= 1'b0;
            k    <= '0;
        end
        else if (begin_sum)
        begin
            busy <= 1'b1;
            k    <= '0;
        end
        else if (busy && k != LAST_K)
            k <= k + 1'b1;
        else if (load)
        begin
            busy <= 1'b0;
            k    <= '0;
        end
        // stalled on last tap otherwise
    end

    always_ff @(posedge axis_clk)
    begin
        if (begin_sum)
            acc <= '0;
        else if (busy && k != LAST_K)
            acc <= sum;
    end

    // ********************
    // output register
    // ********************

    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            out_valid <= 1'b0;
            load_cnt  <= '0;
        end
        else if (run.start_pulse)
        begin
            out_valid <= 1'b0;
            load_cnt  <= '0;
        end
        else if (load)
        begin
            out_valid <= 1'b1;
            load_cnt  <= load_cnt + 1'b1;
        end
        else if (sm_tready)
            out_valid <= 1'b0;
    end

    // results leave in order, so the load count marks the last one
    always_ff @(posedge axis_clk)
    begin
        if (load)
        begin
            out_q.data <= sum;
            out_q.last <= (load_cnt == run.len - 1'b1);
        end
    end

    assign sm_tvalid = out_valid;
    assign sm_out    = out_q;
    assign run_end   = out_valid & sm_tready & out_q.last;

    // held beat must not change under back-pressure
    a_beat_stable: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (sm_tvalid && !sm_tready) |=> (sm_tvalid && $stable(sm_out)));

    // requested tap stays inside the coefficient file
    a_idx_range: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        tap_rd.valid |-> (tap_rd.idx <= LAST_K));

endmodule

// File: rtl/fir_top.sv
// top level of the streaming fir filter, joins register block, sample window and mac
`timescale 1ns/10ps
`include "fir_cfg.svh"

module fir_top (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    // axi-lite write
    input  logic                    awvalid,
    input  logic [`FIR_ADDR_W-1:0]  awaddr,
    input  logic                    wvalid,
    input  logic [`FIR_DATA_W-1:0]  wdata,
    output logic                    awready,
    output logic                    wready,
    // axi-lite read
    input  logic                    arvalid,
    input  logic [`FIR_ADDR_W-1:0]  araddr,
    output logic                    arready,
    output logic                    rvalid,
    output logic [`FIR_DATA_W-1:0]  rdata,
    input  logic                    rready,
    // stream in
    input  logic                    ss_tvalid,
    input  logic [`FIR_DATA_W-1:0]  ss_tdata,
    output logic                    ss_tready,
    // stream out
    output logic                    sm_tvalid,
    input  logic                    sm_tready,
    output logic [`FIR_DATA_W-1:0]  sm_tdata,
    output logic                    sm_tlast
);

    // ********************
    // internal links
    // ********************

    fir_pkg::run_ctrl_t     run;
    fir_pkg::tap_rd_t       tap_rd;
    fir_pkg::axis_beat_t    sm_out;
    logic [`FIR_DATA_W-1:0] tap_coef;
    logic [`FIR_DATA_W-1:0] hist_word;
    logic                   first_take;
    logic                   sample_rdy;
    logic                   sample_ack;
    logic                   run_end;

    // output beat split onto the stream pins
    assign sm_tdata = sm_out.data;
    assign sm_tlast = sm_out.last;

    // registers, coefficient file, status
    axil_cfg u_axil_cfg (
        .axis_clk   (axis_clk),   .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),    .awaddr     (awaddr),
        .wvalid     (wvalid),     .wdata      (wdata),
        .awready    (awready),    .wready     (wready),
        .arvalid    (arvalid),    .araddr     (araddr),
        .arready    (arready),    .rvalid     (rvalid),
        .rdata      (rdata),      .rready     (rready),
        .first_take (first_take), .run_end    (run_end),
        .tap_rd     (tap_rd),     .tap_coef   (tap_coef),
        .run        (run)
    );

    // input side and history
    sample_window u_sample_window (
        .axis_clk   (axis_clk),   .axis_rst_n (axis_rst_n),
        .ss_tvalid  (ss_tvalid),  .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),  .run        (run),
        .sample_ack (sample_ack), .sample_rdy (sample_rdy),
        .first_take (first_take), .tap_rd     (tap_rd),
        .hist_word  (hist_word)
    );

    // tap sequencer and output register
    fir_mac u_fir_mac (
        .axis_clk   (axis_clk),   .axis_rst_n (axis_rst_n),
        .run        (run),        .sample_rdy (sample_rdy),
        .sample_ack (sample_ack), .tap_rd     (tap_rd),
        .tap_coef   (tap_coef),   .hist_word  (hist_word),
        .sm_tvalid  (sm_tvalid),  .sm_tready  (sm_tready),
        .sm_out     (sm_out),     .run_end    (run_end)
    );

endmodule

// File: rtl/sample_window.sv
// input stream stage of the fir filter, keeps the newest eleven samples for the mac
`timescale 1ns/10ps
`include "fir_cfg.svh"

module sample_window (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    ss_tvalid,
    input  logic [`FIR_DATA_W-1:0]  ss_tdata,
    output logic                    ss_tready,
    input  fir_pkg::run_ctrl_t      run,
    input  logic                    sample_ack,
    output logic                    sample_rdy,
    output logic                    first_take,
    input  fir_pkg::tap_rd_t        tap_rd,
    output logic [`FIR_DATA_W-1:0]  hist_word
);

    localparam int TAP_NUM = `FIR_TAP_NUM;

    // win[0] newest, win[k] is x[n-k]
    logic [`FIR_DATA_W-1:0] win [TAP_NUM];
    logic [`FIR_DATA_W-1:0] cnt;
    logic                   held;
    logic                   accept;

    // ********************
    // stream handshake
    // ********************

    // one sample at a time, stop at the length
    assign ss_tready  = run.running & ~held & (cnt < run.len);
    assign accept     = ss_tvalid & ss_tready;
    assign first_take = accept & (cnt == '0);
    assign sample_rdy = held;

    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            cnt  <= '0;
            held <= 1'b0;
        end
        else if (run.start_pulse)
        begin
            cnt  <= '0;
            held <= 1'b0;
        end
        else if (accept)
        begin
            cnt  <= cnt + 1'b1;
            held <= 1'b1;
        end
        else if (sample_ack)
            held <= 1'b0;
    end

    // history, zeroed so early taps see no samples
    always_ff @(posedge axis_clk)
    begin
        if (run.start_pulse)
        begin
            for (int i = 0; i < TAP_NUM; i++)
                win[i] <= '0;
        end
        else if (accept)
        begin
            win[0] <= ss_tdata;
            for (int i = 1; i < TAP_NUM; i++)
                win[i] <= win[i-1];
        end
    end

    assign hist_word = (tap_rd.valid && tap_rd.idx < TAP_NUM) ? win[tap_rd.idx] : '0;

    // once the length is reached, nothing more until the next start
    a_no_take_past_len: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (cnt >= run.len && !run.start_pulse) |=> !(ss_tvalid && ss_tready));

endmodule

// File: verification/fir_tb_checks.svh
// compare tasks and axi-lite bus tasks, included inside the fir testbench module

// ********************
// compare tasks
// ********************

task automatic abort_run(input string why);
    error_count++;
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "run stopped at the first failed check");
endtask

task automatic check_word(input string name, input logic [`FIR_DATA_W-1:0] got,
                          input logic [`FIR_DATA_W-1:0] exp);
    if (got !== exp)
        abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
endtask

task automatic check_beat(input string name, input fir_pkg::axis_beat_t got,
                          input fir_pkg::axis_beat_t exp);
    if (got !== exp)
        abort_run($sformatf("ERR %0t %s got last=%0b data=%h expected last=%0b data=%h",
                            $time, name, got.last, got.data, exp.last, exp.data));
endtask

task automatic check_ctrl(input string name, input fir_pkg::ap_ctrl_t got,
                          input fir_pkg::ap_ctrl_t exp);
    if (got !== exp)
        abort_run($sformatf("ERR %0t %s got idle=%0b done=%0b start=%0b expected %0b %0b %0b",
                            $time, name, got.idle, got.done, got.start,
                            exp.idle, exp.done, exp.start));
endtask

// ********************
// bus tasks
// ********************

// address and data together, both readies answer in the same cycle
task automatic axil_write(input logic [`FIR_ADDR_W-1:0] addr,
                          input logic [`FIR_DATA_W-1:0] data);
    @(negedge axis_clk);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    while (!(awready && wready))
        @(negedge axis_clk);
    @(negedge axis_clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
endtask

// registered read, rdata held until rready
task automatic axil_read(input logic [`FIR_ADDR_W-1:0] addr,
                         output logic [`FIR_DATA_W-1:0] data);
    @(negedge axis_clk);
    arvalid = 1'b1;
    araddr  = addr;
    while (!arready)
        @(negedge axis_clk);
    @(negedge axis_clk);
    arvalid = 1'b0;
    while (!rvalid)
        @(negedge axis_clk);
    data   = rdata;
    rready = 1'b1;
    @(negedge axis_clk);
    rready = 1'b0;
endtask

// File: verification/fir_tb.sv
// testbench of the fir filter top, runs the case table and checks results against a model
`timescale 1ns/10ps
`include "fir_cfg.svh"

module fir_tb;

    localparam int TAP_NUM   = `FIR_TAP_NUM;
    localparam int NUM_CASES = 5;
    localparam int MAX_LEN   = 64;

    // one row of the case table
    typedef struct packed {
        logic [31:0] seed;
        logic [7:0]  len;
        logic [1:0]  gap_mode;
        logic [1:0]  rdy_mode;
    } case_row_t;

    // gap mode 0 back to back, 1 short gaps, 2 longer gaps
    // ready mode 0 always, 1 every other cycle on average, 2 one cycle in four
    localparam case_row_t CASE_TABLE [NUM_CASES] = '{
        '{32'h0000_3a5c, 8'd1,  2'd0, 2'd0},
        '{32'h0005_17e1, 8'd5,  2'd1, 2'd1},
        '{32'h0012_9b40, 8'd20, 2'd2, 2'd2},
        '{32'h7b1d_0042, 8'd40, 2'd1, 2'd2},
        '{32'h0000_9e37, 8'd40, 2'd0, 2'd0}
    };

    logic                   axis_clk, axis_rst_n;
    logic                   awvalid, wvalid, awready, wready;
    logic [`FIR_ADDR_W-1:0] awaddr, araddr;
    logic [`FIR_DATA_W-1:0] wdata, rdata, ss_tdata, sm_tdata;
    logic                   arvalid, arready, rvalid, rready;
    logic                   ss_tvalid, ss_tready, sm_tvalid, sm_tready, sm_tlast;

    int                     error_count = 0;
    logic [31:0]            rng_state   = 32'd14188;
    // set once every result of the current case has been taken
    logic                   outputs_done = 1'b0;
    // coefficients and samples of the current case
    logic [`FIR_DATA_W-1:0] coef_q [TAP_NUM];
    logic [`FIR_DATA_W-1:0] x_mem  [MAX_LEN];

    fir_top dut (.*);

`include "fir_tb_checks.svh"

    // ********************
    // clock and helpers
    // ********************

    initial
    begin
        axis_clk = 1'b0;
        forever #50 axis_clk = ~axis_clk;
    end

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int pick_gap(logic [1:0] mode);
        logic [31:0] r;
        r = next_rand();
        case (mode)
            2'd1:    return int'(r[1:0]);
            2'd2:    return int'(r % 9);
            default: return 0;
        endcase
    endfunction

    function automatic logic pick_ready(logic [1:0] mode);
        logic [31:0] r;
        r = next_rand();
        case (mode)
            2'd1:    return r[0];
            2'd2:    return r[1:0] == 2'b00;
            default: return 1'b1;
        endcase
    endfunction

    // y[n] = sum h[k] x[n-k], samples before the start are zero, low word kept
    function automatic logic [`FIR_DATA_W-1:0] model_output(int n);
        logic [`FIR_DATA_W-1:0] acc;
        acc = '0;
        for (int k = 0; k < TAP_NUM; k++)
        begin
            if (n - k >= 0)
                acc = acc + coef_q[k] * x_mem[n - k];
        end
        return acc;
    endfunction

    function automatic fir_pkg::ap_ctrl_t make_ctrl(logic idle, logic done, logic start);
        return '{idle: idle, done: done, start: start};
    endfunction

    function automatic int watchdog_cycles();
        int total;
        total = 0;
        for (int c = 0; c < NUM_CASES; c++)
            total += int'(CASE_TABLE[c].len) * 30 + 200;
        return total;
    endfunction

    // ********************
    // stream and register steps
    // ********************

    // enters and leaves on a falling edge with ss_tvalid low
    task automatic feed_samples(input int first, input int len, input logic [1:0] gap_mode);
        int gap;
        for (int i = first; i < len; i++)
        begin
            gap = pick_gap(gap_mode);
            repeat (gap) @(negedge axis_clk);
            ss_tvalid = 1'b1;
            ss_tdata  = x_mem[i];
            // held until ready, word moves on the next rising edge
            while (!ss_tready)
                @(negedge axis_clk);
            @(negedge axis_clk);
            ss_tvalid = 1'b0;
        end
    endtask

    // one word too many, offered while results are still draining
    task automatic offer_extra_word();
        ss_tvalid = 1'b1;
        ss_tdata  = ~ss_tdata;
        while (!outputs_done)
        begin
            if (ss_tready)
                abort_run("ss_tready was high after all samples of the run were taken");
            @(negedge axis_clk);
        end
        ss_tvalid = 1'b0;
    endtask

    task automatic collect_outputs(input int len, input logic [1:0] rdy_mode);
        fir_pkg::axis_beat_t exp;
        int                  n;
        n = 0;
        while (n < len)
        begin
            @(negedge axis_clk);
            sm_tready = pick_ready(rdy_mode);
            if (sm_tvalid && sm_tready)
            begin
                exp = '{last: (n == len - 1), data: model_output(n)};
                check_beat($sformatf("sm_out[%0d]", n), {sm_tlast, sm_tdata}, exp);
                n++;
            end
        end
        @(negedge axis_clk);
        sm_tready = 1'b0;
    endtask

    task automatic expect_status(input string name, input fir_pkg::ap_ctrl_t exp);
        logic [`FIR_DATA_W-1:0] word;
        axil_read(`FIR_REG_CTRL, word);
        check_ctrl(name, fir_pkg::ap_ctrl_t'(word[2:0]), exp);
    endtask

    task automatic check_coefs();
        logic [`FIR_DATA_W-1:0] word;
        for (int k = 0; k < TAP_NUM; k++)
        begin
            axil_read(`FIR_REG_TAP0 + 12'(4 * k), word);
            check_word($sformatf("coef[%0d]", k), word, coef_q[k]);
        end
    endtask

    // extra word offered, nothing may move in either direction
    task automatic check_quiet();
        ss_tvalid = 1'b1;
        ss_tdata  = next_rand();
        repeat (4)
        begin
            if (ss_tready)
                abort_run("ss_tready was high after all samples of the run were taken");
            if (sm_tvalid)
                abort_run("sm_tvalid was high after the last result of the run");
            @(negedge axis_clk);
        end
        ss_tvalid = 1'b0;
    endtask

    task automatic run_case(input case_row_t row);
        logic [`FIR_DATA_W-1:0] word;
        int                     len;
        len       = int'(row.len);
        rng_state = rng_state ^ row.seed;
        for (int k = 0; k < TAP_NUM; k++)
        begin
            coef_q[k] = next_rand();
            axil_write(`FIR_REG_TAP0 + 12'(4 * k), coef_q[k]);
        end
        axil_write(`FIR_REG_LEN, 32'(len));
        for (int i = 0; i < len; i++)
            x_mem[i] = next_rand();
        check_coefs();
        axil_read(`FIR_REG_LEN, word);
        check_word("len", word, 32'(len));
        // below the taps, past the last tap, misaligned
        axil_read(12'h004, word);
        check_word("rdata@004", word, `FIR_RDATA_UNMAPPED);
        axil_read(12'h04c, word);
        check_word("rdata@04c", word, `FIR_RDATA_UNMAPPED);
        axil_read(12'h022, word);
        check_word("rdata@022", word, `FIR_RDATA_UNMAPPED);
        expect_status("status before start", make_ctrl(1'b1, 1'b0, 1'b0));
        axil_write(`FIR_REG_CTRL, 32'h1);
        expect_status("status after start", make_ctrl(1'b0, 1'b0, 1'b1));
        // first sample alone, output side still stalled
        feed_samples(0, 1, 2'd0);
        expect_status("status after first sample", make_ctrl(1'b0, 1'b0, 1'b0));
        // coefficient file locked while running
        axil_write(`FIR_REG_TAP0 + 12'h00c, ~coef_q[3]);
        outputs_done = 1'b0;
        fork
            begin
                feed_samples(1, len, row.gap_mode);
                offer_extra_word();
            end
            begin
                collect_outputs(len, row.rdy_mode);
                outputs_done = 1'b1;
            end
        join
        check_quiet();
        expect_status("status after run", make_ctrl(1'b1, 1'b1, 1'b0));
        expect_status("status second read", make_ctrl(1'b1, 1'b0, 1'b0));
        check_coefs();
    endtask

    // ********************
    // main sequence and watchdog
    // ********************

    initial
    begin
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        repeat (2) @(posedge axis_clk);
        @(negedge axis_clk);
        axis_rst_n = 1'b1;
        if (awready || wready || rvalid || ss_tready || sm_tvalid)
            abort_run("a handshake output was high right after reset");
        for (int c = 0; c < NUM_CASES; c++)
            run_case(CASE_TABLE[c]);
        if (error_count == 0)
        begin
            $display("No errors");
            $finish;
        end
        else
        begin
            $display("Errors found");
            $fatal(1, "run ended with failed checks");
        end
    end

    initial
    begin
        int limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge axis_clk);
        abort_run($sformatf("watchdog timeout, tests did not finish in %0d cycles", limit));
    end

endmodule
